/* design/heap_macros.svh */
// ----------------------------------------------------------------------
// Heap memory sizing
// Widths of array numbers, element indices and data words
// ----------------------------------------------------------------------
`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

// ----------------------------------------------------------------------
// Base widths
// ----------------------------------------------------------------------
`define HEAP_ADDRESS_BITS 3     // Bits in an array number
`define HEAP_INDEX_BITS   2     // Bits in an element index
`define HEAP_DATA_BITS    12    // Width of one element

// ----------------------------------------------------------------------
// Derived sizes
// ----------------------------------------------------------------------
`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)   // Number of arrays
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)     // Elements per array

// Extra cycles allowed past the last request before a run is abandoned
`define HEAP_TIMEOUT_MARGIN 50

`endif

/* design/heapPkg.sv */
// ----------------------------------------------------------------------
// Heap memory types
// Opcodes, error codes and the request, status and response words
// ----------------------------------------------------------------------
`include "heap_macros.svh"

package heapPkg;

  // --------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------
  typedef enum logic [4:0] {
    opIdle  = 5'd0,   // No operation
    opReset = 5'd1,   // Clear sizes and allocations
    opAlloc = 5'd2,   // Allocate an array
    opFree  = 5'd3,   // Release an array
    opWrite = 5'd4,   // Store an element
    opRead  = 5'd5,   // Load an element
    opSize  = 5'd6,   // Current array size
    opPush  = 5'd7,   // Append at the end
    opPop   = 5'd8,   // Remove from the end
    opAdd   = 5'd9,   // Add into an element
    opXor   = 5'd10   // Xor into an element
  } heapOp_e;

  typedef enum logic [2:0] {
    errNone        = 3'd0,
    errUnallocated = 3'd1,  // Array not allocated
    errBounds      = 3'd2,  // Index not below size
    errFull        = 3'd3,  // Push to full array
    errEmpty       = 3'd4,  // Pop from empty array
    errNoMemory    = 3'd5   // No array left to allocate
  } heapError_e;

  // --------------------------------------------------------------------
  // Words passed between blocks
  // --------------------------------------------------------------------
  typedef struct packed {
    logic                          valid;   // Request strobe
    heapOp_e                       op;
    logic [`HEAP_ADDRESS_BITS-1:0] array;   // Array number
    logic [`HEAP_INDEX_BITS-1:0]   index;   // Element index
    logic [`HEAP_DATA_BITS-1:0]    data;    // Operand
  } heapRequest_s;

  typedef struct packed {
    logic                          allocated;  // Requested array in use
    logic                          grant;      // Alloc succeeded
    logic [`HEAP_ADDRESS_BITS-1:0] newArray;   // Array handed out
    heapError_e                    error;
  } allocStatus_s;

  typedef struct packed {
    logic [`HEAP_DATA_BITS-1:0] data;
    heapError_e                 error;
  } storeResult_s;

  // Result word seen as plain data or as an array number
  typedef union packed {
    logic [`HEAP_DATA_BITS-1:0] data;
    struct packed {
      logic [`HEAP_DATA_BITS-`HEAP_ADDRESS_BITS-1:0] pad;
      logic [`HEAP_ADDRESS_BITS-1:0]                 arrayId;
    } alloc;
  } heapResult_u;

  typedef struct packed {
    logic        valid;   // One cycle after the request
    heapError_e  error;
    heapResult_u result;
  } heapResponse_s;

endpackage

/* design/arrayAllocator.sv */
// ----------------------------------------------------------------------
// Array allocator
// Tracks which arrays are in use, hands out freed arrays first and
// fresh ones after that
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module arrayAllocator import heapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  heapRequest_s request,
  output allocStatus_s status
);

  logic [`HEAP_ARRAYS-1:0]       allocBits;                    // One bit per array
  logic [`HEAP_ADDRESS_BITS-1:0] freeStack [`HEAP_ARRAYS];     // LIFO of freed arrays
  logic [`HEAP_ADDRESS_BITS:0]   stackDepth;                   // Entries on the stack
  logic [`HEAP_ADDRESS_BITS:0]   freshCount;                   // Next never-used array
  logic [`HEAP_ADDRESS_BITS-1:0] topIndex;
  logic                          stackEmpty;
  logic                          freeOk;

  assign stackEmpty = (stackDepth == '0);
  assign topIndex   = stackDepth[`HEAP_ADDRESS_BITS-1:0] - 1'b1;
  assign freeOk     = request.valid && (request.op == opFree) && status.allocated;

  // ----------------------------------------------------------------------
  // Status for the current request
  // ----------------------------------------------------------------------
  always_comb begin
    status.allocated = allocBits[request.array];
    status.grant     = 1'b0;
    status.newArray  = '0;
    status.error     = errNone;
    if (request.valid && request.op == opAlloc) begin
      if (!stackEmpty) begin
        status.grant    = 1'b1;                    // Reuse the last freed array
        status.newArray = freeStack[topIndex];
      end else if (freshCount < `HEAP_ARRAYS) begin
        status.grant    = 1'b1;
        status.newArray = freshCount[`HEAP_ADDRESS_BITS-1:0];
      end else begin
        status.error = errNoMemory;
      end
    end else if (request.valid && request.op == opFree && !status.allocated) begin
      status.error = errUnallocated;               // Double free or never allocated
    end
  end

  // ----------------------------------------------------------------------
  // State update
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocBits  <= '0;
      stackDepth <= '0;
      freshCount <= '0;
    end else if (request.valid) begin
      case (request.op)
        opReset: begin
          allocBits  <= '0;
          stackDepth <= '0;
          freshCount <= '0;
        end
        opAlloc: begin
          if (status.grant) begin
            allocBits[status.newArray] <= 1'b1;
            if (!stackEmpty) begin
              stackDepth <= stackDepth - 1'b1;     // Popped a freed array
            end else begin
              freshCount <= freshCount + 1'b1;
            end
          end
        end
        opFree: begin
          if (status.allocated) begin
            allocBits[request.array] <= 1'b0;      // Clear the freed array itself
            stackDepth               <= stackDepth + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Freed array numbers, valid below the current depth
  always_ff @(posedge clock) begin
    if (freeOk) begin
      freeStack[stackDepth[`HEAP_ADDRESS_BITS-1:0]] <= request.array;
    end
  end

  // At most every array on the stack at once
  assert property (@(posedge clock) disable iff (!reset)
    stackDepth <= `HEAP_ARRAYS);

  assert property (@(posedge clock) disable iff (!reset)
    !(status.grant && status.error != errNone));

endmodule

/* design/arrayStore.sv */
// ----------------------------------------------------------------------
// Array store
// Element memory and per-array sizes, with the element operations
// and their bounds, full and empty checks
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module arrayStore import heapPkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  heapRequest_s request,
  input  allocStatus_s status,
  output storeResult_s result
);

  logic [`HEAP_DATA_BITS-1:0]  elements [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  logic [`HEAP_INDEX_BITS:0]   sizes    [`HEAP_ARRAYS];    // 0 to array length

  logic [`HEAP_INDEX_BITS:0]   curSize;
  logic [`HEAP_DATA_BITS-1:0]  element;      // Addressed element
  logic [`HEAP_INDEX_BITS-1:0] lastIndex;    // Top element for Pop
  logic                        inBounds;
  logic                        isFull;
  logic                        isEmpty;

  logic                        memWrite;
  logic [`HEAP_INDEX_BITS-1:0] memIndex;
  logic [`HEAP_DATA_BITS-1:0]  memData;
  logic                        sizeWrite;
  logic [`HEAP_INDEX_BITS:0]   sizeNext;

  assign curSize   = sizes[request.array];
  assign element   = elements[request.array][request.index];
  assign lastIndex = curSize[`HEAP_INDEX_BITS-1:0] - 1'b1;
  assign inBounds  = ({1'b0, request.index} < curSize);
  assign isFull    = (curSize == `HEAP_ARRAY_LENGTH);
  assign isEmpty   = (curSize == '0);

  // ----------------------------------------------------------------------
  // Operation decode
  // ----------------------------------------------------------------------
  always_comb begin
    result.data  = '0;
    result.error = errNone;
    memWrite     = 1'b0;
    memIndex     = request.index;
    memData      = request.data;
    sizeWrite    = 1'b0;
    sizeNext     = curSize;
    // Allocation is checked in the allocator, here it only gates access
    if (request.valid && status.allocated) begin
      case (request.op)
        opWrite: begin
          memWrite    = 1'b1;
          result.data = request.data;
          if (!inBounds) begin
            sizeWrite = 1'b1;                        // Grow to cover the index
            sizeNext  = {1'b0, request.index} + 1'b1;
          end
        end
        opRead: begin
          if (inBounds) begin
            result.data = element;
          end else begin
            result.error = errBounds;
          end
        end
        opSize: begin
          result.data = {{(`HEAP_DATA_BITS-`HEAP_INDEX_BITS-1){1'b0}}, curSize};
        end
        opPush: begin
          if (isFull) begin
            result.error = errFull;
          end else begin
            memWrite  = 1'b1;
            memIndex  = curSize[`HEAP_INDEX_BITS-1:0];
            sizeWrite = 1'b1;
            sizeNext  = curSize + 1'b1;
          end
        end
        opPop: begin
          if (isEmpty) begin
            result.error = errEmpty;
          end else begin
            result.data = elements[request.array][lastIndex];
            sizeWrite   = 1'b1;
            sizeNext    = curSize - 1'b1;
          end
        end
        opAdd, opXor: begin
          if (inBounds) begin
            memWrite    = 1'b1;
            memData     = (request.op == opAdd) ? element + request.data
                                                : element ^ request.data;
            result.data = memData;                   // New value, wraps at width
          end else begin
            result.error = errBounds;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) begin
        sizes[a] <= '0;
      end
    end else if (request.valid) begin
      if (request.op == opReset) begin
        for (int a = 0; a < `HEAP_ARRAYS; a++) begin
          sizes[a] <= '0;
        end
      end else if (status.grant) begin
        sizes[status.newArray] <= '0;                // Fresh array starts empty
      end else if (sizeWrite) begin
        sizes[request.array] <= sizeNext;
      end
    end
  end

  // Element memory
  always_ff @(posedge clock) begin
    if (memWrite) begin
      elements[request.array][memIndex] <= memData;
    end
  end

  for (genvar g = 0; g < `HEAP_ARRAYS; g++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (!reset)
      sizes[g] <= `HEAP_ARRAY_LENGTH);
  end

endmodule

/* design/heapResponse.sv */
// ----------------------------------------------------------------------
// Heap response
// Picks the error source and result view, registers the response
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module heapResponse import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  heapRequest_s  request,
  input  allocStatus_s  status,
  input  storeResult_s  result,
  output heapResponse_s response
);

  logic        validQ;
  heapError_e  errorQ;
  heapResult_u resultQ;
  heapError_e  errorNext;
  heapResult_u resultNext;

  // ----------------------------------------------------------------------
  // Error and result selection
  // ----------------------------------------------------------------------
  always_comb begin
    case (request.op)
      opAlloc, opFree: errorNext = status.error;     // Allocator owns these
      opIdle, opReset: errorNext = errNone;
      default: begin
        if (!status.allocated) begin
          errorNext = errUnallocated;
        end else begin
          errorNext = result.error;
        end
      end
    endcase

    if (request.op == opAlloc) begin
      resultNext.alloc.pad     = '0;
      resultNext.alloc.arrayId = status.newArray;    // Zero when not granted
    end else begin
      resultNext.data = result.data;
    end
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      validQ <= 1'b0;
    end else begin
      validQ <= request.valid;
    end
  end

  always_ff @(posedge clock) begin
    errorQ  <= errorNext;
    resultQ <= resultNext;
  end

  assign response = '{valid: validQ, error: errorQ, result: resultQ};

  // Fixed one cycle latency, no back-pressure
  assert property (@(posedge clock) disable iff (!reset)
    1'b1 |=> (response.valid == $past(request.valid)));

endmodule

/* design/heapMemory.sv */
// ----------------------------------------------------------------------
// Heap memory top level
// One request feeds the allocator and the store side by side, and the
// response block merges their results one cycle later
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemory import heapPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  heapRequest_s  request,
  output heapResponse_s response
);

  allocStatus_s allocStatus;    // Allocator to store and response
  storeResult_s storeResult;    // Store to response

  // ----------------------------------------------------------------------
  // Allocation tracking
  // ----------------------------------------------------------------------
  arrayAllocator allocator_i (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .status  (allocStatus)
  );

  // ----------------------------------------------------------------------
  // Element storage
  // ----------------------------------------------------------------------
  arrayStore store_i (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .status  (allocStatus),
    .result  (storeResult)
  );

  // ----------------------------------------------------------------------
  // Registered response
  // ----------------------------------------------------------------------
  heapResponse response_i (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .status   (allocStatus),
    .result   (storeResult),
    .response (response)
  );

endmodule

/* testbench/heapModel.svh */
// ----------------------------------------------------------------------
// Heap reference model
// Allocation table, freed-array stack, sizes and element contents,
// applied one request at a time
// ----------------------------------------------------------------------

bit mAllocated [`HEAP_ARRAYS];
int mFreeList  [$];                                // Last freed at the back
int mFresh;                                        // Next never-used array
int mSize      [`HEAP_ARRAYS];
int mElement   [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
bit mKnown     [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH]; // Written at least once

// Elements survive a clear, only the bookkeeping goes
task automatic modelClear();
  mFreeList.delete();
  mFresh = 0;
  for (int a = 0; a < `HEAP_ARRAYS; a++) begin
    mAllocated[a] = 1'b0;
    mSize[a]      = 0;
  end
endtask

task automatic modelApply(input heapRequest_s req, output heapError_e err,
                          output int data, output bit known);
  int a;
  int i;
  int d;
  a     = req.array;
  i     = req.index;
  d     = req.data;
  err   = errNone;
  data  = 0;
  known = 1'b1;
  if (req.valid) begin
    case (req.op)
      opIdle: begin
      end
      opReset: modelClear();
      opAlloc: begin
        if (mFreeList.size() > 0) begin
          data = mFreeList.pop_back();             // Most recently freed first
        end else if (mFresh < `HEAP_ARRAYS) begin
          data = mFresh++;
        end else begin
          err = errNoMemory;
        end
        if (err == errNone) begin
          mAllocated[data] = 1'b1;
          mSize[data]      = 0;
        end
      end
      opFree: begin
        if (mAllocated[a]) begin
          mAllocated[a] = 1'b0;
          mFreeList.push_back(a);
        end else begin
          err = errUnallocated;
        end
      end
      default: begin
        if (!mAllocated[a]) begin
          err = errUnallocated;
        end else if (req.op == opWrite) begin
          mElement[a][i] = d;
          mKnown[a][i]   = 1'b1;
          mSize[a]       = (i >= mSize[a]) ? i + 1 : mSize[a];
          data           = d;
        end else if (req.op == opSize) begin
          data = mSize[a];
        end else if (req.op == opPush) begin
          if (mSize[a] == `HEAP_ARRAY_LENGTH) begin
            err = errFull;
          end else begin
            mElement[a][mSize[a]] = d;
            mKnown[a][mSize[a]]   = 1'b1;
            mSize[a]++;
          end
        end else if (req.op == opPop) begin
          if (mSize[a] == 0) begin
            err = errEmpty;
          end else begin
            mSize[a]--;
            data  = mElement[a][mSize[a]];
            known = mKnown[a][mSize[a]];
          end
        end else if (i >= mSize[a]) begin
          err = errBounds;                         // Read, Add and Xor
        end else begin
          if (req.op == opAdd) begin
            mElement[a][i] = (mElement[a][i] + d) % (1 << `HEAP_DATA_BITS);
          end else if (req.op == opXor) begin
            mElement[a][i] = mElement[a][i] ^ d;
          end
          data  = mElement[a][i];
          known = mKnown[a][i];
        end
      end
    endcase
  end
endtask

/* testbench/heapMemoryTb.sv */
// ----------------------------------------------------------------------
// Heap memory testbench
// Directed allocation and element tests, then seeded random traffic,
// all checked against the reference model
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapMemoryTb import heapPkg::*; ();

  localparam int RandomCount   = 2000;
  localparam int DirectedCount = 78;   // Requests in tests 1 to 4, flushes included
  localparam int CycleLimit    = 5 + DirectedCount + RandomCount + 1 + `HEAP_TIMEOUT_MARGIN;

  logic          clock;
  logic          reset;
  heapRequest_s  request;
  heapResponse_s response;

  int            errors;
  int            checks;
  int            cycleCount = 0;
  bit            pendValid;            // Expectation for the response in flight
  heapError_e    pendError;
  heapResult_u   pendResult;
  bit            pendKnown;

  `include "heapModel.svh"

  heapMemory dut_i (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .response (response)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == CycleLimit) begin
      $display("Timeout: the run did not end within %0d cycles", CycleLimit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic checkValid(string name, logic actual, logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic checkError(string name, heapError_e actual, heapError_e expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic checkResult(string name, heapResult_u actual, heapResult_u expected);
    checks++;
    if (actual.data !== expected.data) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual.data,
               expected.data);
    end
  endtask

  // ----------------------------------------------------------------------
  // Request driving
  // ----------------------------------------------------------------------
  function automatic heapRequest_s makeRequest(heapOp_e op, int array = 0, int index = 0,
                                               int data = 0);
    heapRequest_s r;
    r.valid = 1'b1;
    r.op    = op;
    r.array = array[`HEAP_ADDRESS_BITS-1:0];
    r.index = index[`HEAP_INDEX_BITS-1:0];
    r.data  = data[`HEAP_DATA_BITS-1:0];
    return r;
  endfunction

  // Drives one request and checks the response to the one before
  task automatic step(input heapRequest_s req);
    heapError_e expError;
    int         expData;
    bit         expKnown;
    @(posedge clock);
    request <= req;
    @(negedge clock);
    checkValid("response.valid", response.valid, pendValid);
    if (pendValid) begin
      checkError("response.error", response.error, pendError);
      if (pendKnown) begin
        checkResult("response.result", response.result, pendResult);
      end
    end
    modelApply(req, expError, expData, expKnown);
    pendValid = req.valid;
    pendError = expError;
    pendKnown = expKnown;
    if (req.op == opAlloc) begin
      pendResult.alloc.pad     = '0;
      pendResult.alloc.arrayId = expData[`HEAP_ADDRESS_BITS-1:0];
    end else begin
      pendResult.data = expData[`HEAP_DATA_BITS-1:0];
    end
  endtask

  task automatic reportTest(string name, int startErrors);
    step('0);                                      // Flush the last response
    $display("Test %s finished with %0d errors", name, errors - startErrors);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic testAfterReset();
    int startErrors;
    startErrors = errors;
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      step(makeRequest(opRead, a, a % `HEAP_ARRAY_LENGTH));
      step(makeRequest(opSize, a));
      step(makeRequest(opPush, a, 0, a + 1));
    end
    reportTest("unallocated access", startErrors);
  endtask

  task automatic testAllocFree();
    int startErrors;
    startErrors = errors;
    step(makeRequest(opReset));
    repeat (`HEAP_ARRAYS + 1) step(makeRequest(opAlloc));   // Last one runs out
    step(makeRequest(opFree, 5));
    step(makeRequest(opFree, 2));
    repeat (2) step(makeRequest(opAlloc));         // Reuses 2, then 5
    step(makeRequest(opFree, 3));
    step(makeRequest(opFree, 3));
    reportTest("alloc and free", startErrors);
  endtask

  task automatic testPushPop();
    int startErrors;
    startErrors = errors;
    step(makeRequest(opReset));
    step(makeRequest(opAlloc));
    for (int k = 0; k < 5; k++) begin
      step(makeRequest(opPush, 0, 0, 'h100 + k));  // Fifth one hits full
      step(makeRequest(opSize, 0));
    end
    for (int k = 0; k < 5; k++) begin
      step(makeRequest(opPop, 0));
      step(makeRequest(opSize, 0));
    end
    reportTest("push and pop", startErrors);
  endtask

  task automatic testElements();
    int startErrors;
    startErrors = errors;
    step(makeRequest(opReset));
    step(makeRequest(opAlloc));
    step(makeRequest(opWrite, 0, 2, 'hff0));
    step(makeRequest(opSize, 0));
    step(makeRequest(opRead, 0, 3));
    step(makeRequest(opRead, 0, 2));
    step(makeRequest(opWrite, 0, 0, 'h123));
    step(makeRequest(opAdd, 0, 2, 'h020));         // Wraps past 12 bits
    step(makeRequest(opXor, 0, 2, 'hfff));
    step(makeRequest(opRead, 0, 1));
    step(makeRequest(opAdd, 0, 3, 'h001));
    step(makeRequest(opSize, 0));
    reportTest("write, read, add, xor", startErrors);
  endtask

  task automatic randomTraffic();
    heapRequest_s req;
    int           startErrors;
    int           rnd;
    startErrors = errors;
    for (int n = 0; n < RandomCount; n++) begin
      rnd       = $urandom;
      req.valid = (rnd[2:0] != 3'd0);              // Idle one cycle in eight
      req.op    = heapOp_e'($urandom_range(int'(opAlloc), int'(opXor)));
      rnd       = $urandom;
      req.array = rnd[`HEAP_ADDRESS_BITS-1:0];
      req.index = rnd[8 +: `HEAP_INDEX_BITS];
      req.data  = rnd[16 +: `HEAP_DATA_BITS];
      if (n == RandomCount / 2) begin
        req.valid = 1'b1;
        req.op    = opReset;                       // Clear everything mid-run
      end
      step(req);
    end
    reportTest("random traffic", startErrors);
  endtask

  initial begin
    void'($urandom(1353));
    clock   = 1'b0;
    reset   = 1'b0;
    request = '0;
    errors  = 0;
    checks  = 0;
    pendValid = 1'b0;
    modelClear();
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    testAfterReset();
    testAllocFree();
    testPushPop();
    testElements();
    randomTraffic();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
+incdir+testbench
design/heapPkg.sv
design/arrayAllocator.sv
design/arrayStore.sv
design/heapResponse.sv
design/heapMemory.sv
testbench/heapMemoryTb.sv

/* Makefile */
# Verilator build and run for the heap memory testbench

VERILATOR ?= verilator
TOP       ?= heapMemoryTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv testbench/*.svh)
BINARY  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
